// ==== hw/spi_pin_sync.sv ====
module spi_pin_sync
    import spi_slave_pkg::*;
(
    input  logic done,
    input  logic S_RESETN,
    input  logic spi_sck,
    input  logic spi_cs,
    input  logic spi_mosi,
    input  logic cpol,
    input  logic cpha,
    input  logic cspol,
    output logic cs_active,
    output logic sample_stb,
    output logic shift_stb,
    output logic mosi_s
);

    logic [SYNC_STAGES-1:0] sck_sync;
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sck_now;
    logic                   sck_prev;
    logic                   lead_edge;
    logic                   trail_edge;

    always_ff @(posedge done or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sck_sync   <= '0;
            cs_sync    <= '1;  // idle for active-low select
            mosi_sync  <= '1;
            sck_prev   <= 1'b0;
            sample_stb <= 1'b0;
            shift_stb  <= 1'b0;
        end else begin
            sck_sync   <= {sck_sync[SYNC_STAGES-2:0], spi_sck};
            cs_sync    <= {cs_sync[SYNC_STAGES-2:0], spi_cs};
            mosi_sync  <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
            sck_prev   <= sck_now;
            sample_stb <= cs_active & (cpha ? trail_edge : lead_edge);
            shift_stb  <= cs_active & (cpha ? lead_edge : trail_edge);
        end
    end

    assign sck_now   = sck_sync[SYNC_STAGES-1];
    assign mosi_s    = mosi_sync[SYNC_STAGES-1];
    assign cs_active = cspol ? cs_sync[SYNC_STAGES-1] : ~cs_sync[SYNC_STAGES-1];

    // leading edge leaves the idle level set by cpol
    assign lead_edge  = (sck_now ^ cpol) & ~(sck_prev ^ cpol);
    assign trail_edge = ~(sck_now ^ cpol) & (sck_prev ^ cpol);

endmodule

// ==== hw/spi_slave_pkg.sv ====
package spi_slave_pkg;

    // wishbone word addresses
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_TXDATA = 2'd1;
    localparam logic [1:0] REG_RXDATA = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    // control register fields
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_CPOL   = 1;
    localparam int CTRL_CPHA   = 2;
    localparam int CTRL_CSPOL  = 3;  // set for active-high cs
    localparam int CTRL_REV    = 4;  // set for msb first
    localparam int CTRL_WIDE   = 5;  // set for 16-bit chars

    // status register fields
    localparam int STAT_RX_VALID = 0;
    localparam int STAT_OVERRUN  = 1;
    localparam int STAT_BUSY     = 2;

    localparam int SYNC_STAGES = 2;

    // one data word, split into byte or halfword chars
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } spi_word_t;

endpackage

// ==== hw/spi_slave_regs.sv ====
module spi_slave_regs
    import spi_slave_pkg::*;
(
    input  logic        done,
    input  logic        S_RESETN,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    input  spi_word_t   rx_word,
    input  logic        word_done,
    input  logic        busy,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        enable,
    output logic        cpol,
    output logic        cpha,
    output logic        cspol,
    output logic        rev,
    output logic        wide,
    output spi_word_t   tx_word
);

    logic [CTRL_WIDE:0] ctrl;
    spi_word_t          rx_data;
    logic               rx_valid;
    logic               overrun;
    logic               req;
    logic               wr_req;
    logic               rd_req;
    logic               rd_rx;
    logic [31:0]        status_word;
    logic [31:0]        rd_mux;

    assign req    = wb_cyc & wb_stb & ~wb_ack;  // one ack per access
    assign wr_req = req & wb_we;
    assign rd_req = req & ~wb_we;
    assign rd_rx  = rd_req & (wb_adr == REG_RXDATA);

    assign enable = ctrl[CTRL_ENABLE];
    assign cpol   = ctrl[CTRL_CPOL];
    assign cpha   = ctrl[CTRL_CPHA];
    assign cspol  = ctrl[CTRL_CSPOL];
    assign rev    = ctrl[CTRL_REV];
    assign wide   = ctrl[CTRL_WIDE];

    always_comb begin
        status_word                = '0;
        status_word[STAT_RX_VALID] = rx_valid;
        status_word[STAT_OVERRUN]  = overrun;
        status_word[STAT_BUSY]     = busy;
    end

    always_comb begin
        case (wb_adr)
            REG_CTRL:   rd_mux = 32'(ctrl);
            REG_TXDATA: rd_mux = tx_word;
            REG_RXDATA: rd_mux = rx_data;
            REG_STATUS: rd_mux = status_word;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge done or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            ctrl     <= '0;
            tx_word  <= '0;
            rx_data  <= '0;
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            wb_ack <= req;
            if (rd_req) begin
                wb_dat_r <= rd_mux;
            end
            if (wr_req && (wb_adr == REG_CTRL)) begin
                ctrl <= wb_dat_w[CTRL_WIDE:0];
            end
            if (wr_req && (wb_adr == REG_TXDATA)) begin
                for (int i = 0; i < 4; i++) begin
                    if (wb_sel[i]) begin
                        tx_word.b[i] <= wb_dat_w[8*i +: 8];  // byte enables
                    end
                end
            end
            if (word_done) begin
                rx_data  <= rx_word;
                rx_valid <= 1'b1;
                overrun  <= rd_rx ? 1'b0 : (overrun | rx_valid);  // unread word lost
            end else if (rd_rx) begin
                rx_valid <= 1'b0;
                overrun  <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/spi_slave_top.sv ====
module spi_slave_top
    import spi_slave_pkg::*;
(
    input  logic        done,
    input  logic        S_RESETN,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    input  logic [3:0]  wb_sel,
    input  logic        spi_sck,
    input  logic        spi_cs,
    input  logic        spi_mosi,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        spi_miso
);

    logic      enable;
    logic      cpol;
    logic      cpha;
    logic      cspol;
    logic      rev;
    logic      wide;
    logic      cs_active;
    logic      sample_stb;
    logic      shift_stb;
    logic      mosi_s;
    logic      word_done;
    logic      busy;
    spi_word_t tx_word;
    spi_word_t rx_word;

    spi_pin_sync u_sync (
        .done       (done),
        .S_RESETN   (S_RESETN),
        .spi_sck    (spi_sck),
        .spi_cs     (spi_cs),
        .spi_mosi   (spi_mosi),
        .cpol       (cpol),
        .cpha       (cpha),
        .cspol      (cspol),
        .cs_active  (cs_active),
        .sample_stb (sample_stb),
        .shift_stb  (shift_stb),
        .mosi_s     (mosi_s)
    );

    spi_slave_trx_char u_trx (
        .done       (done),
        .S_RESETN   (S_RESETN),
        .enable     (enable),
        .cpha       (cpha),
        .rev        (rev),
        .wide       (wide),
        .cs_active  (cs_active),
        .sample_stb (sample_stb),
        .shift_stb  (shift_stb),
        .mosi_s     (mosi_s),
        .tx_word    (tx_word),
        .spi_miso   (spi_miso),
        .rx_word    (rx_word),
        .word_done  (word_done),
        .busy       (busy)
    );

    spi_slave_regs u_regs (
        .done      (done),
        .S_RESETN  (S_RESETN),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .rx_word   (rx_word),
        .word_done (word_done),
        .busy      (busy),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .enable    (enable),
        .cpol      (cpol),
        .cpha      (cpha),
        .cspol     (cspol),
        .rev       (rev),
        .wide      (wide),
        .tx_word   (tx_word)
    );

endmodule

// ==== hw/spi_slave_trx_char.sv ====
module spi_slave_trx_char
    import spi_slave_pkg::*;
(
    input  logic      done,
    input  logic      S_RESETN,
    input  logic      enable,
    input  logic      cpha,
    input  logic      rev,
    input  logic      wide,
    input  logic      cs_active,
    input  logic      sample_stb,
    input  logic      shift_stb,
    input  logic      mosi_s,
    input  spi_word_t tx_word,
    output logic      spi_miso,
    output spi_word_t rx_word,
    output logic      word_done,
    output logic      busy
);

    logic        active;
    logic        active_q;
    logic [3:0]  bit_cnt;
    logic [1:0]  char_idx;
    logic [3:0]  last_bit;
    logic [1:0]  last_idx;
    logic        char_end;
    logic        load_char;
    logic        tx_step;
    spi_word_t   tx_lat;
    spi_word_t   tx_src;
    logic [15:0] tx_char;
    logic [15:0] tx_cur;
    logic [15:0] tx_sh;
    logic [15:0] rx_sh;
    logic [15:0] rx_next;
    spi_word_t   rx_asm;

    assign active   = enable & cs_active;
    assign busy     = active;
    assign last_bit = wide ? 4'd15 : 4'd7;
    assign last_idx = wide ? 2'd1 : 2'd3;
    assign char_end = (bit_cnt == last_bit);

    // cpha 0 presents bit 0 at select, otherwise on the first shift edge of a char
    assign load_char = (active & ~active_q & ~cpha) | (shift_stb & (bit_cnt == 4'd0));
    assign tx_step   = load_char | shift_stb;

    assign tx_src  = (char_idx == 2'd0) ? tx_word : tx_lat;  // fresh word at lane 0
    assign tx_char = wide ? tx_src.h[char_idx[0]] : {8'h00, tx_src.b[char_idx]};
    assign tx_cur  = load_char ? tx_char : tx_sh;

    // new bit enters on the side opposite the first one sent
    assign rx_next = rev ? {rx_sh[14:0], mosi_s} : {mosi_s, rx_sh[15:1]};

    assign rx_word = rx_asm;

    always_ff @(posedge done or negedge S_RESETN) begin
        if (!S_RESETN) begin
            active_q  <= 1'b0;
            bit_cnt   <= '0;
            char_idx  <= '0;
            word_done <= 1'b0;
            spi_miso  <= 1'b1;
        end else begin
            active_q  <= active;
            word_done <= 1'b0;
            if (!active) begin
                bit_cnt  <= '0;  // partial word dropped
                char_idx <= '0;
                spi_miso <= 1'b1;
            end else begin
                if (tx_step) begin
                    spi_miso <= rev ? (wide ? tx_cur[15] : tx_cur[7]) : tx_cur[0];
                end
                if (sample_stb) begin
                    if (char_end) begin
                        bit_cnt <= '0;
                        if (char_idx == last_idx) begin
                            char_idx  <= '0;
                            word_done <= 1'b1;
                        end else begin
                            char_idx <= char_idx + 2'd1;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge done) begin
        if (active && tx_step) begin
            tx_sh <= rev ? {tx_cur[14:0], 1'b0} : {1'b0, tx_cur[15:1]};
        end
        if (active && load_char && (char_idx == 2'd0)) begin
            tx_lat <= tx_word;
        end
        if (active && sample_stb) begin
            rx_sh <= rx_next;
            if (char_end) begin
                if (wide) begin
                    rx_asm.h[char_idx[0]] <= rx_next;
                end else begin
                    rx_asm.b[char_idx] <= rev ? rx_next[7:0] : rx_next[15:8];
                end
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI slave testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv \
    -f spi_slave_top.f \
    --top-module spi_slave_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vspi_slave_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== spi_slave_top.f ====
hw/spi_slave_pkg.sv
hw/spi_pin_sync.sv
hw/spi_slave_trx_char.sv
hw/spi_slave_regs.sv
hw/spi_slave_top.sv
test/spi_slave_checker.sv
test/spi_slave_monitor.sv
test/spi_slave_tb.sv

// ==== test/spi_slave_checker.sv ====
module spi_slave_checker (
    input logic done,
    input logic S_RESETN,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic word_done,
    input logic overrun
);

    ack_one_cycle: assert property (@(posedge done) disable iff (!S_RESETN)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    ack_after_stb: assert property (@(posedge done) disable iff (!S_RESETN)
        wb_ack |-> $past(wb_cyc & wb_stb))
        else $error("wb_ack without a preceding strobe");

    overrun_from_word: assert property (@(posedge done) disable iff (!S_RESETN)
        $rose(overrun) |-> $past(word_done))
        else $error("overrun rose without word_done");

endmodule

bind spi_slave_regs spi_slave_checker u_chk (
    .done      (done),
    .S_RESETN  (S_RESETN),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .word_done (word_done),
    .overrun   (overrun)
);

// ==== test/spi_slave_monitor.sv ====
module spi_slave_monitor
    import spi_slave_pkg::*;
(
    input logic        done,
    input logic        S_RESETN,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [1:0]  wb_adr,
    input logic [31:0] wb_dat_w,
    input logic [3:0]  wb_sel,
    input logic [31:0] wb_dat_r,
    input logic        wb_ack,
    input logic        spi_sck,
    input logic        spi_cs,
    input logic        spi_miso,
    input logic        check_en,
    input logic [31:0] exp_data
);

    int          errors;
    logic [5:0]  ctrl_exp;
    logic [31:0] tx_exp;
    logic [31:0] miso_bits;
    int          bit_n;
    logic        sck_q;
    logic        link_on;
    logic        sample_edge;

    // lanes leave lowest first with bits in each lane ordered by rev
    function automatic logic [31:0] ref_char_stream(input logic [31:0] w, input logic wide,
                                                    input logic rev);
        int          clen;
        logic [31:0] s;
        clen = wide ? 16 : 8;
        s = '0;
        for (int c = 0; c < 32 / clen; c++) begin
            for (int k = 0; k < clen; k++) begin
                s[c*clen + k] = rev ? w[c*clen + clen - 1 - k] : w[c*clen + k];
            end
        end
        return s;
    endfunction

    assign link_on = ctrl_exp[CTRL_ENABLE] & (spi_cs == ctrl_exp[CTRL_CSPOL]);
    // master samples on leading edge for cpha 0, trailing for cpha 1
    assign sample_edge = (spi_sck != sck_q) &
                         ((spi_sck != ctrl_exp[CTRL_CPOL]) == !ctrl_exp[CTRL_CPHA]);

    always @(posedge done or negedge S_RESETN) begin : watch
        logic [31:0] got;
        if (!S_RESETN) begin
            errors    <= 0;
            ctrl_exp  <= '0;
            tx_exp    <= '0;
            miso_bits <= '0;
            bit_n     <= 0;
            sck_q     <= 1'b0;
        end else begin
            sck_q <= spi_sck;
            if (wb_cyc && wb_stb && wb_ack && wb_we) begin
                if (wb_adr == REG_CTRL)
                    ctrl_exp <= wb_dat_w[5:0];
                if (wb_adr == REG_TXDATA) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wb_sel[i])
                            tx_exp[8*i +: 8] <= wb_dat_w[8*i +: 8];
                    end
                end
            end
            if (wb_cyc && wb_stb && wb_ack && !wb_we && check_en && wb_dat_r !== exp_data) begin
                errors <= errors + 1;
                $display("[ERROR] %s read adr %0d expected %h actual %h",
                         spi_slave_tb.test_name, wb_adr, exp_data, wb_dat_r);
            end
            if (!link_on) begin
                bit_n <= 0;  // partial word dropped
            end else if (sample_edge) begin
                got = miso_bits;
                got[bit_n] = spi_miso;
                miso_bits <= got;
                bit_n <= (bit_n == 31) ? 0 : bit_n + 1;
                if (bit_n == 31 && got !== ref_char_stream(tx_exp, ctrl_exp[CTRL_WIDE],
                                                           ctrl_exp[CTRL_REV])) begin
                    errors <= errors + 1;
                    $display("[ERROR] %s miso stream expected %h actual %h",
                             spi_slave_tb.test_name,
                             ref_char_stream(tx_exp, ctrl_exp[CTRL_WIDE], ctrl_exp[CTRL_REV]),
                             got);
                end
            end
        end
    end

endmodule

// ==== test/spi_slave_tb.sv ====
module spi_slave_tb
    import spi_slave_pkg::*;
();

    localparam int HALF      = 8;   // done cycles per sck phase
    localparam int NUM_WORDS = 24;
    localparam longint LIMIT = longint'(NUM_WORDS) * 32 * 16 * 40 + 200000;

    logic        done;
    logic        S_RESETN;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        spi_sck;
    logic        spi_cs;
    logic        spi_mosi;
    logic        spi_miso;
    logic        check_en;
    logic [31:0] exp_data;
    string       test_name;
    int          tb_errors;
    logic [31:0] rng;
    logic        cur_cpol;
    logic        cur_cpha;
    logic        cur_cspol;
    logic        cur_rev;
    logic        cur_wide;

    spi_slave_top u_dut (.*);

    spi_slave_monitor u_mon (.*);

    initial begin
        done = 1'b0;
        forever #20 done = ~done;
    end

    initial begin
        #(LIMIT);
        $display("watchdog expired, the run hung");
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge done);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        wb_sel   <= sel;
        do begin
            @(posedge done);
            n++;
        end while (!wb_ack && n < 8);
        if (!wb_ack) begin
            tb_errors++;
            $display("wishbone access to %0d got no ack", adr);
        end
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic check_read(input logic [1:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        check_en <= 1'b1;
        exp_data <= exp;
        wb_access(1'b0, adr, '0, 4'hf, rd);
        check_en <= 1'b0;
    endtask

    task automatic wait_rx_valid();
        logic [31:0] st;
        int          n;
        n = 0;
        do begin
            wb_access(1'b0, REG_STATUS, '0, 4'hf, st);
            n++;
        end while (!st[STAT_RX_VALID] && n < 20);
        if (!st[STAT_RX_VALID]) begin
            tb_errors++;
            $display("%s: receive valid flag never set", test_name);
        end
    endtask

    task automatic set_mode(input logic cpol, input logic cpha, input logic cspol,
                            input logic rev, input logic wide);
        logic [31:0] ctrl;
        ctrl = {26'd0, wide, rev, cspol, cpha, cpol, 1'b0};
        wb_write(REG_CTRL, ctrl, 4'hf);  // disabled while pins settle
        @(posedge done);
        spi_cs  <= ~cspol;
        spi_sck <= cpol;
        {cur_cpol, cur_cpha, cur_cspol, cur_rev, cur_wide} = {cpol, cpha, cspol, rev, wide};
        repeat (6) @(posedge done);
        wb_write(REG_CTRL, ctrl | 32'd1, 4'hf);
    endtask

    // spi master for one word, cut short by nbits
    task automatic spi_word(input logic [31:0] w, input int nbits, input logic cs_on);
        logic [31:0] bits;
        bits = u_mon.ref_char_stream(w, cur_wide, cur_rev);
        @(posedge done);
        spi_cs  <= cs_on;
        spi_sck <= cur_cpol;
        repeat (HALF) @(posedge done);
        for (int i = 0; i < nbits; i++) begin
            if (!cur_cpha) begin
                spi_mosi <= bits[i];
                repeat (HALF) @(posedge done);
                spi_sck <= ~cur_cpol;
                repeat (HALF) @(posedge done);
                spi_sck <= cur_cpol;
            end else begin
                spi_sck  <= ~cur_cpol;
                spi_mosi <= bits[i];
                repeat (HALF) @(posedge done);
                spi_sck <= cur_cpol;
                repeat (HALF) @(posedge done);
            end
        end
        repeat (HALF) @(posedge done);
        spi_cs <= ~cur_cspol;
        repeat (HALF) @(posedge done);
    endtask

    initial begin
        logic [31:0] w1;
        logic [31:0] w2;
        S_RESETN <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        wb_sel   <= '0;
        spi_sck  <= 1'b0;
        spi_cs   <= 1'b1;
        spi_mosi <= 1'b1;
        check_en <= 1'b0;
        exp_data <= '0;
        tb_errors = 0;
        rng = 32'd24;
        test_name = "reset";
        repeat (2) @(posedge done);
        S_RESETN <= 1'b1;
        check_read(REG_CTRL, 32'd0);
        check_read(REG_RXDATA, 32'd0);
        check_read(REG_STATUS, 32'd0);

        for (int wide = 0; wide < 2; wide++) begin
            for (int mode = 0; mode < 4; mode++) begin
                for (int rev = 0; rev < 2; rev++) begin
                    test_name = $sformatf("sweep_w%0d_m%0d_r%0d", wide, mode, rev);
                    set_mode(mode[1], mode[0], 1'b0, rev[0], wide[0]);
                    wb_write(REG_TXDATA, next_rand(), 4'hf);
                    w1 = next_rand();
                    spi_word(w1, 32, 1'b0);
                    wait_rx_valid();
                    check_read(REG_RXDATA, w1);
                end
            end
        end

        test_name = "cs_polarity";
        set_mode(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        w1 = next_rand();
        spi_word(w1, 32, 1'b1);
        wait_rx_valid();
        check_read(REG_RXDATA, w1);
        spi_word(next_rand(), 32, 1'b0);  // wrong level, nothing received
        check_read(REG_STATUS, 32'd0);

        test_name = "overrun";
        set_mode(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        w1 = next_rand();
        w2 = next_rand();
        spi_word(w1, 32, 1'b0);
        spi_word(w2, 32, 1'b0);
        wait_rx_valid();
        check_read(REG_STATUS, 32'h3);
        check_read(REG_RXDATA, w2);
        check_read(REG_STATUS, 32'd0);

        test_name = "cs_abort";
        spi_word(next_rand(), 16, 1'b0);
        w1 = next_rand();
        spi_word(w1, 32, 1'b0);
        wait_rx_valid();
        check_read(REG_RXDATA, w1);

        test_name = "registers";
        set_mode(1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
        check_read(REG_CTRL, 32'h35);
        wb_write(REG_TXDATA, 32'ha5a5_a5a5, 4'hf);
        wb_write(REG_TXDATA, next_rand(), 4'b0101);
        w1 = next_rand();
        spi_word(w1, 32, 1'b0);
        wait_rx_valid();
        check_read(REG_RXDATA, w1);

        repeat (4) @(posedge done);
        $display("errors: monitor %0d, testbench %0d", u_mon.errors, tb_errors);
        if (u_mon.errors == 0 && tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
